// File: Makefile
TOP = tb_spi_master

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) \
		-f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: flist.f
spi_pkg.sv
spi_master_fifo.sv
spi_master_io.sv
spi_master_regs.sv
spi_master.sv
tb_spi_master.sv

// File: spi_master.sv
/*
 * spi master top
 * register block -> tx fifo -> shift engine
 */
`timescale 1ns/1ps

module spi_master
  (
   input  logic                   clk,
   input  logic                   nreset,
   input  logic                   access_in,
   input  spi_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   output logic                   access_out,
   output spi_pkg::emesh_packet_t packet_out,
   input  logic                   wait_in,
   output logic                   sclk,
   output logic                   mosi,
   input  logic                   miso,
   output logic                   ss
  );

   import spi_pkg::*;

   logic        tx_push;       // regs -> fifo
   logic [7:0]  tx_byte;
   logic        fifo_full;     // fifo -> regs
   logic        fifo_prog_full;
   logic        fifo_empty;    // fifo -> engine
   logic [7:0]  tx_byte_out;
   logic        tx_pop;        // engine -> fifo
   spi_cfg_t    cfg;           // regs -> engine
   logic [7:0]  clkdiv;
   logic [63:0] rx_data;       // engine -> regs
   logic        rx_access;
   logic        busy;

   spi_master_regs u_regs
     (.clk            (clk),
      .nreset         (nreset),
      .access_in      (access_in),
      .packet_in      (packet_in),
      .wait_out       (wait_out),
      .access_out     (access_out),
      .packet_out     (packet_out),
      .wait_in        (wait_in),
      .tx_push        (tx_push),
      .tx_byte        (tx_byte),
      .fifo_full      (fifo_full),
      .fifo_prog_full (fifo_prog_full),
      .cfg            (cfg),
      .clkdiv         (clkdiv),
      .rx_data        (rx_data),
      .rx_access      (rx_access),
      .busy           (busy));

   spi_master_fifo u_fifo
     (.clk       (clk),
      .nreset    (nreset),
      .push      (tx_push),
      .din       (tx_byte),
      .pop       (tx_pop),
      .dout      (tx_byte_out),
      .full      (fifo_full),
      .prog_full (fifo_prog_full),
      .empty     (fifo_empty));

   spi_master_io u_io
     (.clk        (clk),
      .nreset     (nreset),
      .cfg        (cfg),
      .clkdiv     (clkdiv),
      .fifo_empty (fifo_empty),
      .tx_byte    (tx_byte_out),
      .tx_pop     (tx_pop),
      .rx_data    (rx_data),
      .rx_access  (rx_access),
      .busy       (busy),
      .sclk       (sclk),
      .mosi       (mosi),
      .miso       (miso),
      .ss         (ss));

endmodule

// File: spi_master_fifo.sv
/*
 * tx byte fifo
 * circular buffer with occupancy count, full/prog_full/empty flags
 */
`timescale 1ns/1ps

module spi_master_fifo
  (
   input  logic       clk,
   input  logic       nreset,
   input  logic       push,        // write din this cycle
   input  logic [7:0] din,
   input  logic       pop,         // drop head this cycle
   output logic [7:0] dout,        // head entry
   output logic       full,
   output logic       prog_full,   // at or above almost-full level
   output logic       empty
  );

   import spi_pkg::*;

   logic [7:0]         mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_AW:0]   count;    // 0..FIFO_DEPTH
   logic               do_push;
   logic               do_pop;

   // ignore push when full, pop when empty
   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   //########################################
   // storage
   //########################################

   always_ff @(posedge clk)
      if (do_push)
         mem[wr_ptr] <= din;

   assign dout = mem[rd_ptr];   // valid while empty is low

   //########################################
   // pointers and count
   //########################################

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         wr_ptr <= '0;
      else if (do_push)
         wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         rd_ptr <= '0;
      else if (do_pop)
         rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         count <= '0;
      else
         case ({do_push, do_pop})
            2'b10   : count <= count + 1'b1;
            2'b01   : count <= count - 1'b1;
            default : count <= count;   // both or neither
         endcase

   // flags
   assign full      = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign prog_full = (count >= (FIFO_AW+1)'(FIFO_PROG_FULL));
   assign empty     = (count == '0);

endmodule

// File: spi_master_io.sv
/*
 * spi shift engine
 * pops tx bytes, divides clk into sclk, shifts mosi/miso, drives ss
 */
`timescale 1ns/1ps

module spi_master_io
  (
   input  logic              clk,
   input  logic              nreset,
   input  spi_pkg::spi_cfg_t cfg,
   input  logic [7:0]        clkdiv,       // half period = clkdiv+1 clk
   input  logic              fifo_empty,
   input  logic [7:0]        tx_byte,      // fifo head
   output logic              tx_pop,
   output logic [63:0]       rx_data,      // received byte history
   output logic              rx_access,    // one pulse per byte
   output logic              busy,
   output logic              sclk,
   output logic              mosi,
   input  logic              miso,
   output logic              ss
  );

   typedef enum logic [1:0] {IDLE, SETUP, SHIFT, DONE} state_t;

   state_t     state;
   logic [7:0] div_cnt;      // clk cycles within a half period
   logic [3:0] half_cnt;     // 16 half periods per byte
   logic [7:0] tx_shift;
   logic [7:0] rx_byte;
   logic       enable;
   logic       start;        // pop and load the next byte
   logic       tick;         // end of a half period
   logic       toggle;       // sclk edge this cycle
   logic       sample_edge;
   logic       shift_edge;

   assign enable = ~cfg.dis;
   assign start  = enable & ~fifo_empty & ((state == IDLE) | (state == DONE));
   assign tx_pop = start;
   assign busy   = (state != IDLE);

   //########################################
   // sclk timing
   //########################################

   assign tick   = (div_cnt >= clkdiv);   // >= survives a clkdiv drop
   assign toggle = (state == SHIFT) & tick;

   // even half_cnt is the leading edge
   // cpha=0 samples leading, cpha=1 samples trailing
   assign sample_edge = toggle & (half_cnt[0] == cfg.cpha);
   // cpha=1 first bit already on mosi, skip the first leading shift
   assign shift_edge  = toggle & (half_cnt[0] != cfg.cpha)
                        & ~(cfg.cpha & (half_cnt == 4'd0));

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         div_cnt <= '0;
      else if ((state == IDLE) | (state == DONE) | tick)
         div_cnt <= '0;
      else
         div_cnt <= div_cnt + 1'b1;

   //########################################
   // control FSM
   //########################################

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         state     <= IDLE;
         ss        <= 1'b1;
         sclk      <= 1'b0;   // cpol reset value
         half_cnt  <= '0;
         rx_access <= 1'b0;
      end
      else
      begin
         rx_access <= (state == DONE);   // lines up with rx_data update
         case (state)
            IDLE :
            begin
               sclk <= cfg.cpol;   // park at idle level
               ss   <= ~start;
               if (start)
                  state <= SETUP;
            end
            SETUP :
            begin
               half_cnt <= '0;
               if (tick)   // ss setup of one half period
                  state <= SHIFT;
            end
            SHIFT :
               if (tick)
               begin
                  sclk     <= ~sclk;
                  half_cnt <= half_cnt + 1'b1;
                  if (half_cnt == 4'd15)
                     state <= DONE;
               end
            default :   // DONE, chain or release ss
               if (start)
                  state <= SETUP;
               else
               begin
                  state <= IDLE;
                  ss    <= 1'b1;
               end
         endcase
      end

   //########################################
   // datapath
   //########################################

   assign mosi = cfg.lsbfirst ? tx_shift[0] : tx_shift[7];

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         tx_shift <= '0;   // quiet mosi out of reset
      else if (start)
         tx_shift <= tx_byte;
      else if (shift_edge)
         tx_shift <= cfg.lsbfirst ? {1'b0, tx_shift[7:1]} : {tx_shift[6:0], 1'b0};

   // rx byte built in the same bit order as tx
   always_ff @(posedge clk)
      if (sample_edge)
         rx_byte <= cfg.lsbfirst ? {miso, rx_byte[7:1]} : {rx_byte[6:0], miso};

   always_ff @(posedge clk)
      if (state == DONE)
         rx_data <= {rx_data[55:0], rx_byte};   // newest byte low

endmodule

// File: spi_master_regs.sv
/*
 * spi master register block
 * decodes emesh packets, holds config/status/clkdiv/rx,
 * pushes tx bytes and returns read responses
 */
`timescale 1ns/1ps

module spi_master_regs
  (
   input  logic                   clk,
   input  logic                   nreset,
   // request side
   input  logic                   access_in,
   input  spi_pkg::emesh_packet_t packet_in,
   output logic                   wait_out,
   // response side
   output logic                   access_out,
   output spi_pkg::emesh_packet_t packet_out,
   input  logic                   wait_in,
   // tx fifo
   output logic                   tx_push,
   output logic [7:0]             tx_byte,
   input  logic                   fifo_full,
   input  logic                   fifo_prog_full,
   // engine
   output spi_pkg::spi_cfg_t      cfg,
   output logic [7:0]             clkdiv,
   input  logic [63:0]            rx_data,
   input  logic                   rx_access,
   input  logic                   busy
  );

   import spi_pkg::*;

   logic        accept;        // access taken this cycle
   logic        resp_hold;     // response stalled by wait_in
   logic        reg_write;
   logic        reg_read;
   logic [5:0]  addr;          // decoded offset
   logic        config_write;
   logic        status_write;
   logic        clkdiv_write;
   logic [7:0]  status_reg;
   logic [63:0] rx_reg;        // last rx history snapshot

   //########################################
   // decode
   //########################################

   // stall while the fifo is full or a response sits under wait_in
   assign resp_hold = access_out & wait_in;
   assign wait_out  = fifo_full | resp_hold;
   assign accept    = access_in & ~wait_out;

   assign reg_write = accept & packet_in.write;
   assign reg_read  = accept & ~packet_in.write;
   assign addr      = packet_in.dstaddr[5:0];

   assign config_write = reg_write & (addr == SPI_CONFIG);
   assign status_write = reg_write & (addr == SPI_STATUS);
   assign clkdiv_write = reg_write & (addr == SPI_CLKDIV);

   // tx byte lands in the fifo on the edge ending the accept cycle
   assign tx_push = reg_write & (addr == SPI_TX);
   assign tx_byte = packet_in.data[7:0];

   //########################################
   // config and clkdiv
   //########################################

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         cfg <= '0;   // enabled, mode 0, msb first
      else if (config_write)
         cfg <= spi_cfg_t'(packet_in.data[7:0]);   // all 8 bits kept

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         clkdiv <= CLKDIV_RESET;
      else if (clkdiv_write)
         clkdiv <= packet_in.data[7:0];

   //########################################
   // status
   //########################################

   // write clears for a cycle, then live values come back
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         status_reg <= '0;
      else if (status_write)
         status_reg <= '0;
      else
         status_reg <= {5'b0,                          // 7:3 unused
                        fifo_prog_full,                // 2
                        busy,                          // 1
                        (rx_access | status_reg[0])};  // 0 sticky rx

   // snapshot of the engine's shift history
   always_ff @(posedge clk)
      if (rx_access)
         rx_reg <= rx_data;

   //########################################
   // read response
   //########################################

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         access_out <= 1'b0;
      else if (!resp_hold)
         access_out <= reg_read;   // one cycle after the read

   // reads only accepted when nothing is held, so payload is safe
   always_ff @(posedge clk)
      if (reg_read)
      begin
         packet_out.write    <= 1'b1;
         packet_out.datamode <= packet_in.datamode;
         packet_out.ctrlmode <= packet_in.ctrlmode;
         packet_out.dstaddr  <= packet_in.srcaddr;   // back to requester
         packet_out.srcaddr  <= '0;
         case (addr)
            SPI_CONFIG : packet_out.data <= {{(AW-8){1'b0}}, cfg};
            SPI_STATUS : packet_out.data <= {{(AW-8){1'b0}}, status_reg};
            SPI_CLKDIV : packet_out.data <= {{(AW-8){1'b0}}, clkdiv};
            SPI_RX0    : packet_out.data <= rx_reg[31:0];
            SPI_RX1    : packet_out.data <= rx_reg[63:32];
            default    : packet_out.data <= BAD_READ_DATA;
         endcase
      end

endmodule

// File: spi_pkg.sv
/*
 * spi master shared definitions
 * emesh packet layout, register map, config bits, fifo sizing
 */
package spi_pkg;

   //########################################
   // bus widths
   //########################################

   localparam int AW = 32;   // address and data width, only one build

   // emesh packet, 104 bits, msb first
   typedef struct packed {
      logic          write;      // 1=write, 0=read
      logic [1:0]    datamode;   // access size, echoed on reads
      logic [4:0]    ctrlmode;   // echoed on reads
      logic [AW-1:0] dstaddr;    // register address
      logic [AW-1:0] srcaddr;    // return address for reads
      logic [AW-1:0] data;       // write data or read data
   } emesh_packet_t;

   //########################################
   // register map
   //########################################

   // decoded from dstaddr[5:0]
   localparam logic [5:0] SPI_CONFIG = 6'h00;   // config bits
   localparam logic [5:0] SPI_STATUS = 6'h04;   // rx flag, busy, fifo level
   localparam logic [5:0] SPI_CLKDIV = 6'h08;   // sclk divider
   localparam logic [5:0] SPI_TX     = 6'h10;   // tx fifo push
   localparam logic [5:0] SPI_RX0    = 6'h20;   // rx history, low word
   localparam logic [5:0] SPI_RX1    = 6'h24;   // rx history, high word

   // config register layout
   typedef struct packed {
      logic [2:0] rsvd_hi;    // 7:5 stored, read back only
      logic       lsbfirst;   // 4 shift lsb first
      logic       cpha;       // 3 sample on trailing edge
      logic       cpol;       // 2 sclk idle level
      logic       rsvd_lo;    // 1 stored, read back only
      logic       dis;        // 0 engine off when set
   } spi_cfg_t;

   localparam logic [7:0] CLKDIV_RESET = 8'd1;   // half period = 2 clk

   //########################################
   // fifo sizing
   //########################################

   localparam int FIFO_DEPTH     = 8;                    // tx entries
   localparam int FIFO_PROG_FULL = 4;                    // almost-full level
   localparam int FIFO_AW        = $clog2(FIFO_DEPTH);   // pointer width

   // returned for any unmapped read
   localparam logic [AW-1:0] BAD_READ_DATA = 32'hDEADBEEF;

endpackage

// File: tb_spi_master.sv
/*
 * spi master testbench
 * directed register and transfer tests with mosi looped back to miso
 */
`timescale 1ns/1ps

module tb_spi_master;

   import spi_pkg::*;

   localparam int NUM_TESTS  = 6;
   localparam int WAIT_LIMIT = 100000;   // clk cycles per single wait

   logic          clk;
   logic          nreset;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic          sclk;
   logic          mosi;
   logic          miso;
   logic          ss;

   integer     seed;
   int         errors;
   int         checks;
   int         tests_run;
   logic       cur_cpol;     // mode last written to CONFIG
   logic       cur_cpha;
   logic       cur_lsb;
   logic       last_sclk;
   logic       mon_q[$];     // mosi bits seen on sample edges
   logic [7:0] sent_q[$];    // bytes written to TX

   spi_master UUT
     (.clk        (clk),
      .nreset     (nreset),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .wait_out   (wait_out),
      .access_out (access_out),
      .packet_out (packet_out),
      .wait_in    (wait_in),
      .sclk       (sclk),
      .mosi       (mosi),
      .miso       (miso),
      .ss         (ss));

   assign miso = mosi;   // loopback

   initial
      clk = 1'b0;
   always #20 clk = ~clk;   // 40 ns period

   //########################################
   // mosi monitor
   //########################################

   // sclk edges seen at falling clk edges where mosi is stable
   always @(negedge clk)
   begin
      if (!ss && (sclk != last_sclk) && ((sclk != cur_cpol) != cur_cpha))
         mon_q.push_back(mosi);   // leading edge for cpha 0 and trailing for cpha 1
      last_sclk = sclk;
   end

   //########################################
   // helpers
   //########################################

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("[FAIL] %0t ns: %s = %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   // drive at a falling edge and hold until wait_out is low
   task automatic send(input emesh_packet_t pkt);
      int n;
      n = 0;
      access_in = 1'b1;
      packet_in = pkt;
      while (wait_out && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (wait_out)
      begin
         $display("timeout at %0t ns: wait_out stayed high, packet not taken", $time);
         errors++;
      end
      @(negedge clk);   // accepted on the rising edge just passed
      access_in = 1'b0;
   endtask

   task automatic write_reg(input logic [5:0] addr, input logic [31:0] data);
      emesh_packet_t pkt;
      pkt         = '0;
      pkt.write   = 1'b1;
      pkt.dstaddr = {26'b0, addr};
      pkt.data    = data;
      send(pkt);
   endtask

   // response is due one cycle after the accept edge
   task automatic read_reg(input logic [5:0] addr, output logic [31:0] data);
      emesh_packet_t pkt;
      pkt          = '0;
      pkt.datamode = 2'b10;
      pkt.ctrlmode = 5'h15;
      pkt.dstaddr  = {26'b0, addr};
      pkt.srcaddr  = {16'hC0DE, 10'b0, addr};   // return address
      send(pkt);
      if (!access_out)
      begin
         $display("no read response one cycle after the read of offset %h", addr);
         errors++;
      end
      check_val("packet_out.write", 32'(packet_out.write), 32'd1);
      check_val("packet_out.dstaddr", packet_out.dstaddr, pkt.srcaddr);
      check_val("packet_out.ctrlmode", 32'(packet_out.ctrlmode), 32'h15);
      check_val("packet_out.datamode", 32'(packet_out.datamode), 32'h2);
      data = packet_out.data;
   endtask

   task automatic read_expect(input logic [5:0] addr, input logic [31:0] exp,
                              input logic [31:0] mask, input string name);
      logic [31:0] got;
      read_reg(addr, got);
      check_val(name, got & mask, exp & mask);
   endtask

   task automatic wait_ss(input logic level);
      int n;
      n = 0;
      while ((ss !== level) && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (ss !== level)
      begin
         $display("timeout at %0t ns: ss never went to %b", $time, level);
         errors++;
      end
   endtask

   task automatic set_mode(input logic cpol, input logic cpha, input logic lsb);
      cur_cpol = cpol;
      cur_cpha = cpha;
      cur_lsb  = lsb;
      write_reg(SPI_CONFIG, {27'b0, lsb, cpha, cpol, 2'b00});
      repeat (2) @(negedge clk);   // sclk parks one cycle later
   endtask

   task automatic clear_capture();
      mon_q.delete();
      sent_q.delete();
   endtask

   task automatic send_byte();
      logic [7:0] b;
      b = 8'($random(seed));
      sent_q.push_back(b);
      write_reg(SPI_TX, {24'b0, b});
   endtask

   // bit k of a byte in wire order
   function automatic logic expected_bit(input logic [7:0] b, input int k,
                                         input logic lsb);
      if (lsb)
         return ((b >> k) & 8'h01) != 8'h00;
      else
         return ((b << k) & 8'h80) != 8'h00;
   endfunction

   task automatic compare_bits();
      int   n;
      int   k;
      logic exp_bit;
      n = sent_q.size() * 8;
      checks++;
      if (mon_q.size() != n)
      begin
         $display("[FAIL] %0t ns: mosi bit count = %0d, expected %0d",
                  $time, mon_q.size(), n);
         errors++;
      end
      else
         for (k = 0; k < n; k++)
         begin
            exp_bit = expected_bit(sent_q[k / 8], k % 8, cur_lsb);
            if (mon_q[k] !== exp_bit)
            begin
               $display("[FAIL] %0t ns: mosi bit %0d = %b, expected %b",
                        $time, k, mon_q[k], exp_bit);
               errors++;
            end
         end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests_run++;
      $display("%0t ns: test %s finished, %0d errors", $time, name,
               errors - err_before);
   endtask

   //########################################
   // tests
   //########################################

   task automatic reset_values();
      int e;
      e = errors;
      read_expect(SPI_CONFIG, 32'h0, 32'hFFFF_FFFF, "CONFIG");
      read_expect(SPI_CLKDIV, {24'b0, CLKDIV_RESET}, 32'hFFFF_FFFF, "CLKDIV");
      read_expect(SPI_STATUS, 32'h0, 32'hFFFF_FFFF, "STATUS");
      read_expect(6'h3C, BAD_READ_DATA, 32'hFFFF_FFFF, "unmapped read");
      finish_test("reset_values", e);
   endtask

   task automatic register_readback();
      int            e;
      logic [7:0]    div;
      emesh_packet_t pkt;
      emesh_packet_t held;
      e   = errors;
      div = 8'($random(seed));
      write_reg(SPI_CLKDIV, {24'b0, div});
      read_expect(SPI_CLKDIV, {24'b0, div}, 32'hFFFF_FFFF, "CLKDIV");
      write_reg(SPI_CONFIG, 32'hE2);   // reserved bits set too
      read_expect(SPI_CONFIG, 32'hE2, 32'hFFFF_FFFF, "CONFIG");
      @(negedge clk);   // config read response retires
      // stall the next response with wait_in
      wait_in     = 1'b1;
      pkt         = '0;
      pkt.dstaddr = {26'b0, SPI_CLKDIV};
      send(pkt);
      held = packet_out;
      check_val("held read data", held.data, {24'b0, div});
      repeat (5)
      begin
         check_val("access_out", 32'(access_out), 32'd1);
         check_val("wait_out", 32'(wait_out), 32'd1);
         checks++;
         if (packet_out !== held)
         begin
            $display("packet_out changed at %0t ns while wait_in was high", $time);
            errors++;
         end
         @(negedge clk);
      end
      wait_in = 1'b0;
      @(negedge clk);
      check_val("access_out", 32'(access_out), 32'd0);
      write_reg(SPI_CLKDIV, 32'h1);
      set_mode(1'b0, 1'b0, 1'b0);
      finish_test("register_readback", e);
   endtask

   task automatic mode0_transfer();
      int e;
      e = errors;
      set_mode(1'b0, 1'b0, 1'b0);
      clear_capture();
      send_byte();
      wait_ss(1'b0);
      wait_ss(1'b1);
      compare_bits();
      repeat (2) @(negedge clk);   // rx snapshot lands after ss rises
      read_expect(SPI_RX0, {24'b0, sent_q[0]}, 32'hFF, "RX0[7:0]");
      read_expect(SPI_STATUS, 32'h1, 32'h1, "STATUS.rx");
      finish_test("mode0_transfer", e);
   endtask

   task automatic all_modes();
      int e;
      int m;
      e = errors;
      for (m = 0; m < 8; m++)
      begin
         set_mode(m[0], m[1], m[2]);   // cpol, cpha, lsbfirst
         check_val("sclk idle", 32'(sclk), 32'(cur_cpol));
         clear_capture();
         send_byte();
         send_byte();
         wait_ss(1'b0);
         wait_ss(1'b1);
         compare_bits();
         check_val("sclk idle", 32'(sclk), 32'(cur_cpol));
         repeat (2) @(negedge clk);
         read_expect(SPI_RX0, {16'b0, sent_q[0], sent_q[1]}, 32'hFFFF, "RX0[15:0]");
      end
      set_mode(1'b0, 1'b0, 1'b0);
      finish_test("all_modes", e);
   endtask

   task automatic fifo_backpressure();
      int e;
      int i;
      int n;
      e = errors;
      clear_capture();
      write_reg(SPI_CLKDIV, 32'd15);   // slow enough to fill behind it
      write_reg(SPI_CONFIG, 32'h1);    // engine off
      for (i = 0; i < FIFO_DEPTH - 1; i++)
         send_byte();
      check_val("ss while disabled", 32'(ss), 32'd1);
      read_expect(SPI_STATUS, 32'h4, 32'h4, "STATUS.prog_full");
      write_reg(SPI_CONFIG, 32'h0);    // first byte pops right away
      send_byte();
      send_byte();
      check_val("wait_out on full fifo", 32'(wait_out), 32'd1);
      n = 0;
      while (wait_out && (n < WAIT_LIMIT))
      begin
         @(negedge clk);
         n++;
      end
      if (wait_out)
      begin
         $display("timeout at %0t ns: wait_out never fell after enable", $time);
         errors++;
      end
      wait_ss(1'b1);
      compare_bits();
      write_reg(SPI_CLKDIV, 32'h1);
      finish_test("fifo_backpressure", e);
   endtask

   task automatic status_clear();
      int e;
      e = errors;
      write_reg(SPI_STATUS, 32'h0);
      read_expect(SPI_STATUS, 32'h0, 32'h1, "STATUS.rx after clear");
      write_reg(SPI_CLKDIV, 32'd31);
      clear_capture();
      send_byte();
      wait_ss(1'b0);
      repeat (4) @(negedge clk);
      read_expect(SPI_STATUS, 32'h2, 32'h2, "STATUS.busy in transfer");
      wait_ss(1'b1);
      compare_bits();
      repeat (2) @(negedge clk);
      read_expect(SPI_STATUS, 32'h1, 32'h3, "STATUS after transfer");
      write_reg(SPI_CLKDIV, 32'h1);
      finish_test("status_clear", e);
   endtask

   //########################################
   // main sequence and watchdog
   //########################################

   initial
   begin
      seed      = 98;
      errors    = 0;
      checks    = 0;
      tests_run = 0;
      cur_cpol  = 1'b0;
      cur_cpha  = 1'b0;
      cur_lsb   = 1'b0;
      last_sclk = 1'b0;
      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0;
      repeat (10) @(negedge clk);   // reset held 10 cycles
      nreset = 1'b1;
      @(negedge clk);
      reset_values();
      register_readback();
      mode0_transfer();
      all_modes();
      fifo_backpressure();
      status_clear();
      $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   // tests x 20 bytes x 16 half periods x 256 clk x 40 ns
   initial
   begin
      #(NUM_TESTS * 20 * 16 * 256 * 40);
      $display("watchdog expired at %0t ns, tests did not finish", $time);
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
